//--- networkadapter_ct.f
+incdir+sim
logic/na_pkg.sv
logic/na_flit_fifo.sv
logic/na_conf_regs.sv
logic/na_bus_decode.sv
logic/na_mp_send.sv
logic/na_mp_recv.sv
logic/networkadapter_ct.sv
sim/tb_networkadapter_ct.sv

//--- run_sim.sh
#!/bin/sh
# Build the network adapter testbench with Verilator and run it.
# The run passes only if the testbench reports a pass.
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 -f networkadapter_ct.f --top-module tb_networkadapter_ct &&
./obj_dir/Vtb_networkadapter_ct | tee /dev/stderr | grep -F "TB PASSED" > /dev/null ||
{ echo "Simulation did not pass"; exit 1; }

//--- sim/tb_checks.svh
/* Testbench checks
 * Compare tasks, Wishbone access tasks and check counters
 */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

localparam int BUS_TIMEOUT = 50;                 // Cycles per bus wait

int checks_run = 0;
int errors     = 0;

task automatic check_word(input string test, input logic [31:0] exp, input logic [31:0] act);
   checks_run++;
   if (act !== exp) begin
      errors++;
      $display("MISMATCH %s expected 0x%08h actual 0x%08h", test, exp, act);
   end
endtask

task automatic check_flit(input string test, input na_pkg::flit_t exp, input na_pkg::flit_t act);
   checks_run++;
   if (act !== exp) begin
      errors++;
      $display("MISMATCH %s expected type %0d data 0x%08h actual type %0d data 0x%08h",
               test, exp.ftype, exp.data, act.ftype, act.data);
   end
endtask

task automatic check_bit(input string test, input logic exp, input logic act);
   checks_run++;
   if (act !== exp) begin
      errors++;
      $display("MISMATCH %s expected %b actual %b", test, exp, act);
   end
endtask

// One classic cycle, request held until ack or err
task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] wdat,
                         output logic [31:0] rdat, output logic ack, output logic err);
   int waited;
   waited = 0;
   @(negedge clk);
   wbs_req     = '0;
   wbs_req.adr = adr;
   wbs_req.dat = wdat;
   wbs_req.sel = 4'hf;                           // Whole word
   wbs_req.we  = we;
   wbs_req.cyc = 1'b1;
   wbs_req.stb = 1'b1;
   do begin
      @(negedge clk);                            // Response registered on the rising edge
      waited++;
   end while (!wbs_rsp.ack && !wbs_rsp.err && waited < BUS_TIMEOUT);
   rdat    = wbs_rsp.dat;
   ack     = wbs_rsp.ack;
   err     = wbs_rsp.err;
   wbs_req = '0;                                 // Master drops stb
   if (!ack && !err) begin
      errors++;
      $display("Bus access to address 0x%08h got neither ack nor err in time", adr);
   end
endtask

task automatic bus_read(input logic [31:0] adr, output logic [31:0] data,
                        output logic ack, output logic err);
   wb_access(1'b0, adr, 32'h0, data, ack, err);
endtask

task automatic bus_write(input logic [31:0] adr, input logic [31:0] data,
                         output logic ack, output logic err);
   logic [31:0] rdat;
   wb_access(1'b1, adr, data, rdat, ack, err);
endtask

`endif

//--- sim/tb_networkadapter_ct.sv
/* Testbench for the compute tile network adapter
 * Directed tests of configuration, bus errors, send and receive paths
 */
`timescale 1ns/1ps
`default_nettype none

module tb_networkadapter_ct;

   localparam int TILE        = 3;
   localparam int NOC_TIMEOUT = 200;             // Cycles per NoC wait

   logic            clk = 1'b0;
   logic            rst_n;
   na_pkg::wb_req_t wbs_req;
   na_pkg::wb_rsp_t wbs_rsp;
   na_pkg::flit_t   noc_in_flit;
   logic            noc_in_valid;
   logic            noc_in_ready;
   na_pkg::flit_t   noc_out_flit;
   logic            noc_out_valid;
   logic            noc_out_ready;
   logic            irq;
   integer          seed = 55394;
   logic [31:0]     sent_q [$];                  // Words of the packet being sent

   `include "tb_checks.svh"

   networkadapter_ct #(
      .TILE_ID (TILE)
   ) networkadapter_ct_i (
      .clk_i           (clk),
      .rst_n_i         (rst_n),
      .wbs_req_i       (wbs_req),
      .wbs_rsp_o       (wbs_rsp),
      .noc_in_flit_i   (noc_in_flit),
      .noc_in_valid_i  (noc_in_valid),
      .noc_in_ready_o  (noc_in_ready),
      .noc_out_flit_o  (noc_out_flit),
      .noc_out_valid_o (noc_out_valid),
      .noc_out_ready_i (noc_out_ready),
      .irq_o           (irq)
   );

   always #5 clk = ~clk;                         // 100 MHz

   function automatic logic [31:0] reg_addr(input logic [na_pkg::REGION_W-1:0] region,
                                            input logic [na_pkg::OFFS_W-1:0]   offs);
      return (32'(region) << na_pkg::REGION_LSB) | (32'(offs) << 2);
   endfunction

   // Single flit or header then payloads then last
   function automatic na_pkg::flit_type_t flit_kind(input int idx, input int len);
      if (len == 1)
         return na_pkg::FLIT_SINGLE;
      else if (idx == 0)
         return na_pkg::FLIT_HEADER;
      else if (idx == len - 1)
         return na_pkg::FLIT_LAST;
      else
         return na_pkg::FLIT_PAYLOAD;
   endfunction

   task automatic report_test(input string name, input int errs_before);
      $display("Test %s done, %0d errors", name, errors - errs_before);
   endtask

   task automatic read_and_check(input string test, input logic [31:0] adr,
                                 input logic [31:0] exp);
      logic [31:0] data;
      logic        ack;
      logic        err;
      bus_read(adr, data, ack, err);
      check_bit({test, " ack"}, 1'b1, ack);
      check_word(test, exp, data);
   endtask

   task automatic write_acked(input string test, input logic [31:0] adr, input logic [31:0] dat);
      logic ack;
      logic err;
      bus_write(adr, dat, ack, err);
      check_bit({test, " ack"}, 1'b1, ack);
   endtask

   // Length then random words with nothing released before the last
   task automatic send_packet(input int len);
      logic [31:0] word;
      sent_q.delete();
      write_acked("send length", reg_addr(na_pkg::REGION_MP, na_pkg::MP_DATA), 32'(len));
      for (int i = 0; i < len; i++) begin
         word = $random(seed);
         sent_q.push_back(word);
         write_acked("send word", reg_addr(na_pkg::REGION_MP, na_pkg::MP_DATA), word);
         if (i == len - 2)
            check_bit("send held back", 1'b0, noc_out_valid);
      end
   endtask

   // Random back-pressure with each flit taken where valid and ready meet
   task automatic collect_flits(input string test, input int len);
      na_pkg::flit_t exp;
      int            idx;
      int            waited;
      int            r;
      idx    = 0;
      waited = 0;
      while (idx < len && waited < NOC_TIMEOUT) begin
         @(negedge clk);
         r             = $random(seed);
         noc_out_ready = r[0];
         if (noc_out_ready && noc_out_valid) begin
            exp.ftype = flit_kind(idx, len);
            exp.data  = sent_q[idx];
            check_flit(test, exp, noc_out_flit);
            idx++;
         end
         waited++;
      end
      @(negedge clk);
      noc_out_ready = 1'b0;
      if (idx < len) begin
         errors++;
         $display("%s: only %0d of %0d flits left the adapter in time", test, idx, len);
      end
   endtask

   task automatic push_flit(input na_pkg::flit_t f);
      int   waited;
      logic taken;
      waited = 0;
      @(negedge clk);
      noc_in_flit  = f;
      noc_in_valid = 1'b1;
      while (!noc_in_ready && waited < NOC_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      taken = noc_in_ready;                      // Ready only moves on the rising edge
      @(negedge clk);                            // Taken on the edge in between
      noc_in_valid = 1'b0;
      if (!taken) begin
         errors++;
         $display("NoC input stayed not ready, flit 0x%08h not taken", f.data);
      end
   endtask

   task automatic wait_irq(input logic level);
      int waited;
      waited = 0;
      while (irq !== level && waited < NOC_TIMEOUT) begin
         @(negedge clk);
         waited++;
      end
      if (irq !== level) begin
         errors++;
         $display("Interrupt did not reach level %b in time", level);
      end
   endtask

   task automatic test_reset_state();
      int e0;
      e0 = errors;
      check_bit("reset ack", 1'b0, wbs_rsp.ack);
      check_bit("reset err", 1'b0, wbs_rsp.err);
      check_bit("reset out valid", 1'b0, noc_out_valid);
      check_bit("reset irq", 1'b0, irq);
      check_bit("reset in ready", 1'b1, noc_in_ready);
      report_test("reset state", e0);
   endtask

   task automatic test_config();
      int e0;
      e0 = errors;
      read_and_check("conf tile", reg_addr(na_pkg::REGION_CONF, na_pkg::CONF_TILEID), 32'd3);
      read_and_check("conf xdim", reg_addr(na_pkg::REGION_CONF, na_pkg::CONF_XDIM), 32'd2);
      read_and_check("conf ydim", reg_addr(na_pkg::REGION_CONF, na_pkg::CONF_YDIM), 32'd2);
      read_and_check("conf cores", reg_addr(na_pkg::REGION_CONF, na_pkg::CONF_NUMCORES), 32'd4);
      read_and_check("conf base", reg_addr(na_pkg::REGION_CONF, na_pkg::CONF_COREBASE), 32'd0);
      read_and_check("conf feat", reg_addr(na_pkg::REGION_CONF, na_pkg::CONF_FEATURES), 32'd1);
      report_test("config read-back", e0);
   endtask

   task automatic test_bus_errors();
      logic [31:0] data;
      logic        ack;
      logic        err;
      int          e0;
      e0 = errors;
      bus_write(reg_addr(na_pkg::REGION_CONF, na_pkg::CONF_TILEID), 32'h55, ack, err);
      check_bit("conf write err", 1'b1, err);
      check_bit("conf write ack", 1'b0, ack);
      bus_read(reg_addr(2'd2, '0), data, ack, err);  // Unmapped region
      check_bit("region 2 err", 1'b1, err);
      check_bit("region 2 ack", 1'b0, ack);
      bus_write(reg_addr(na_pkg::REGION_MP, na_pkg::MP_DATA), 32'd0, ack, err);
      check_bit("zero length err", 1'b1, err);
      check_bit("zero length ack", 1'b0, ack);
      report_test("bus errors", e0);
   endtask

   task automatic test_send();
      int e0;
      e0 = errors;
      send_packet(1);
      collect_flits("send single", 1);
      send_packet(5);
      collect_flits("send five", 5);
      check_bit("send drained", 1'b0, noc_out_valid);
      report_test("send", e0);
   endtask

   task automatic test_receive();
      logic [31:0]   words [3];
      na_pkg::flit_t f;
      int            e0;
      e0 = errors;
      check_bit("recv irq before", 1'b0, irq);
      for (int i = 0; i < 3; i++) begin
         words[i] = $random(seed);
         f.ftype  = flit_kind(i, 3);
         f.data   = words[i];
         push_flit(f);
      end
      wait_irq(1'b1);
      read_and_check("recv status", reg_addr(na_pkg::REGION_MP, na_pkg::MP_STATUS), 32'd1);
      read_and_check("recv length", reg_addr(na_pkg::REGION_MP, na_pkg::MP_DATA), 32'd3);
      for (int i = 0; i < 3; i++)
         read_and_check("recv word", reg_addr(na_pkg::REGION_MP, na_pkg::MP_DATA), words[i]);
      report_test("receive", e0);
   endtask

   task automatic test_drained();
      int e0;
      e0 = errors;
      check_bit("drained irq", 1'b0, irq);
      read_and_check("drained status", reg_addr(na_pkg::REGION_MP, na_pkg::MP_STATUS), 32'd0);
      read_and_check("drained data", reg_addr(na_pkg::REGION_MP, na_pkg::MP_DATA), 32'd0);
      report_test("irq clear and empty read", e0);
   endtask

   initial begin
      rst_n         = 1'b0;
      wbs_req       = '0;
      noc_in_flit   = '0;
      noc_in_valid  = 1'b0;
      noc_out_ready = 1'b0;
      repeat (10) @(posedge clk);                // Reset for 10 cycles
      @(negedge clk);
      rst_n = 1'b1;
      test_reset_state();
      test_config();
      test_bus_errors();
      test_send();
      test_receive();
      test_drained();
      $display("Summary: %0d checks, %0d errors", checks_run, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- logic/networkadapter_ct.sv
/* Compute tile network adapter
 * Bus decoder, configuration block and message passing on one NoC channel
 */
`timescale 1ns/1ps
`default_nettype none

module networkadapter_ct #(
   parameter int TILE_ID = 0
) (
   input  wire logic              clk_i,
   input  wire logic              rst_n_i,
   input  wire na_pkg::wb_req_t   wbs_req_i,
   output na_pkg::wb_rsp_t        wbs_rsp_o,
   input  wire na_pkg::flit_t     noc_in_flit_i,
   input  wire logic              noc_in_valid_i,
   output logic                   noc_in_ready_o,
   output na_pkg::flit_t          noc_out_flit_o,
   output logic                   noc_out_valid_o,
   input  wire logic              noc_out_ready_i,
   output logic                   irq_o
);

   na_pkg::wb_req_t conf_req;
   na_pkg::wb_rsp_t conf_rsp;
   na_pkg::wb_req_t mp_req;
   na_pkg::wb_rsp_t mp_rsp;
   logic            send_ack;
   logic            send_err;

   na_bus_decode u_decode (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wbs_req_i  (wbs_req_i),
      .wbs_rsp_o  (wbs_rsp_o),
      .conf_req_o (conf_req),
      .conf_rsp_i (conf_rsp),
      .mp_req_o   (mp_req),
      .mp_rsp_i   (mp_rsp)                        // Merged in receive path
   );

   na_conf_regs #(
      .TILE_ID (TILE_ID)
   ) u_conf (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (conf_req),
      .rsp_o   (conf_rsp)
   );

   na_mp_send u_mp_send (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_i       (mp_req),                      // Writes only
      .ack_o       (send_ack),
      .err_o       (send_err),
      .noc_flit_o  (noc_out_flit_o),
      .noc_valid_o (noc_out_valid_o),
      .noc_ready_i (noc_out_ready_i)
   );

   na_mp_recv u_mp_recv (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_i       (mp_req),                      // Reads only
      .rsp_o       (mp_rsp),
      .send_ack_i  (send_ack),
      .send_err_i  (send_err),
      .noc_flit_i  (noc_in_flit_i),
      .noc_valid_i (noc_in_valid_i),
      .noc_ready_o (noc_in_ready_o),
      .irq_o       (irq_o)
   );

endmodule

`default_nettype wire

//--- logic/na_mp_recv.sv
/* Message-passing receive path
 * Buffers whole packets from the NoC, queues their lengths, raises irq
 * Bus reads drain length then words; owns the merged message-passing response
 */
`timescale 1ns/1ps
`default_nettype none

module na_mp_recv (
   input  wire logic              clk_i,
   input  wire logic              rst_n_i,
   input  wire na_pkg::wb_req_t   req_i,
   output na_pkg::wb_rsp_t        rsp_o,
   input  wire logic              send_ack_i,
   input  wire logic              send_err_i,
   input  wire na_pkg::flit_t     noc_flit_i,
   input  wire logic              noc_valid_i,
   output logic                   noc_ready_o,
   output logic                   irq_o
);

   logic [na_pkg::LEN_W-1:0]      lq_mem [na_pkg::MP_LEN_QUEUE_DEPTH];
   logic [na_pkg::LQ_PTR_W-1:0]   lq_wr;
   logic [na_pkg::LQ_PTR_W-1:0]   lq_rd;
   logic [na_pkg::LQ_CNT_W-1:0]   lq_cnt;
   logic                          lq_full;
   logic                          lq_empty;
   logic                          lq_push;
   logic                          lq_pop;
   logic [na_pkg::LEN_W-1:0]      in_cnt_q;      // Flits of arriving packet
   logic                          flit_in;
   logic                          fifo_wr_ready;
   na_pkg::flit_t                 fifo_out;
   logic                          fifo_out_valid;
   logic [na_pkg::OFFS_W-1:0]     offs;
   logic                          rd_seen;
   logic                          data_rd;
   logic                          payload_rd;
   logic                          last_word;
   logic [na_pkg::LEN_W-1:0]      head_len;
   logic [na_pkg::LEN_W-1:0]      rd_cnt_q;      // Words read of head packet
   logic                          hdr_done_q;    // Length word already read
   logic [na_pkg::WB_DAT_W-1:0]   rdata;
   logic [na_pkg::WB_DAT_W-1:0]   rd_dat_q;
   logic                          rd_ack_q;

   // NoC side
   assign lq_full     = (lq_cnt == na_pkg::LQ_CNT_FULL);
   assign lq_empty    = (lq_cnt == '0);
   assign noc_ready_o = fifo_wr_ready & ~lq_full;
   assign flit_in     = noc_valid_i & noc_ready_o;
   assign lq_push     = flit_in & ((noc_flit_i.ftype == na_pkg::FLIT_LAST) |
                                   (noc_flit_i.ftype == na_pkg::FLIT_SINGLE));
   assign irq_o       = ~lq_empty;

   // Bus side
   assign offs       = req_i.adr[na_pkg::REGION_LSB-1:2];
   assign rd_seen    = req_i.cyc & req_i.stb & ~req_i.we & ~rd_ack_q;
   assign data_rd    = rd_seen & (offs == na_pkg::MP_DATA) & ~lq_empty;
   assign payload_rd = data_rd & hdr_done_q & fifo_out_valid;
   assign head_len   = lq_mem[lq_rd];
   assign last_word  = (rd_cnt_q == head_len - 1'b1);
   assign lq_pop     = payload_rd & last_word;

   always_comb begin
      rdata = '0;                                 // Empty queue reads 0
      if (offs == na_pkg::MP_STATUS)
         rdata = 32'(lq_cnt);
      else if (offs == na_pkg::MP_DATA && !lq_empty)
         rdata = hdr_done_q ? fifo_out.data : 32'(head_len);
   end

   always_ff @(posedge clk_i) begin
      if (lq_push)
         lq_mem[lq_wr] <= in_cnt_q + 1'b1;
      if (rd_seen)
         rd_dat_q <= rdata;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         lq_wr      <= '0;
         lq_rd      <= '0;
         lq_cnt     <= '0;
         in_cnt_q   <= '0;
         rd_cnt_q   <= '0;
         hdr_done_q <= 1'b0;
         rd_ack_q   <= 1'b0;
      end else begin
         rd_ack_q <= rd_seen;                     // Reads ack next cycle
         if (flit_in)
            in_cnt_q <= lq_push ? '0 : in_cnt_q + 1'b1;
         if (lq_push)
            lq_wr <= lq_wr + 1'b1;
         if (lq_pop)
            lq_rd <= lq_rd + 1'b1;
         case ({lq_push, lq_pop})
            2'b10:   lq_cnt <= lq_cnt + 1'b1;
            2'b01:   lq_cnt <= lq_cnt - 1'b1;
            default: lq_cnt <= lq_cnt;
         endcase
         if (data_rd && !hdr_done_q) begin
            hdr_done_q <= 1'b1;                   // Length served
            rd_cnt_q   <= '0;
         end else if (payload_rd) begin
            if (last_word)
               hdr_done_q <= 1'b0;                // Next read starts a packet
            else
               rd_cnt_q <= rd_cnt_q + 1'b1;
         end
      end
   end

   // Single combining point of the message-passing response
   assign rsp_o.dat = rd_dat_q;
   assign rsp_o.ack = rd_ack_q | send_ack_i;
   assign rsp_o.err = send_err_i;

   na_flit_fifo u_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wr_flit_i  (noc_flit_i),
      .wr_valid_i (noc_valid_i & ~lq_full),
      .wr_ready_o (fifo_wr_ready),
      .rd_flit_o  (fifo_out),
      .rd_valid_o (fifo_out_valid),
      .rd_ready_i (payload_rd),
      .count_o    ()
   );

endmodule

`default_nettype wire

//--- logic/na_mp_send.sv
/* Message-passing send path
 * Takes a length and N words from the bus, types them and queues the flits
 * Flits are held back until the whole packet is in the FIFO
 */
`timescale 1ns/1ps
`default_nettype none

module na_mp_send (
   input  wire logic              clk_i,
   input  wire logic              rst_n_i,
   input  wire na_pkg::wb_req_t   req_i,
   output logic                   ack_o,
   output logic                   err_o,
   output na_pkg::flit_t          noc_flit_o,
   output logic                   noc_valid_o,
   input  wire logic              noc_ready_i
);

   typedef enum logic {
      S_IDLE,                                     // Waiting for length
      S_COLLECT                                   // Taking payload words
   } state_t;

   state_t                          state;
   logic [na_pkg::LEN_W-1:0]        len_q;
   logic [na_pkg::LEN_W-1:0]        cnt_q;        // Words of open packet
   logic                            ack_q;
   logic                            err_q;
   logic                            wr_seen;
   logic                            is_data;
   logic                            len_ok;
   na_pkg::flit_t                   fifo_in;
   logic                            fifo_valid;
   logic                            fifo_ready;
   logic                            fifo_out_valid;
   logic [na_pkg::FIFO_CNT_W-1:0]   fifo_count;
   logic                            release_ok;

   assign wr_seen    = req_i.cyc & req_i.stb & req_i.we & ~ack_q & ~err_q;
   assign is_data    = (req_i.adr[na_pkg::REGION_LSB-1:2] == na_pkg::MP_DATA);
   assign len_ok     = (req_i.dat != '0) && (req_i.dat <= 32'(na_pkg::MP_FIFO_DEPTH));
   assign fifo_valid = wr_seen & is_data & (state == S_COLLECT);

   always_comb begin
      fifo_in.data = req_i.dat;
      if (len_q == 1)
         fifo_in.ftype = na_pkg::FLIT_SINGLE;
      else if (cnt_q == '0)
         fifo_in.ftype = na_pkg::FLIT_HEADER;
      else if (cnt_q == len_q - 1'b1)
         fifo_in.ftype = na_pkg::FLIT_LAST;
      else
         fifo_in.ftype = na_pkg::FLIT_PAYLOAD;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state <= S_IDLE;
         len_q <= '0;
         cnt_q <= '0;
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
         if (wr_seen && !is_data) begin
            err_q <= 1'b1;                        // Status word is read-only
         end else if (wr_seen && state == S_IDLE) begin
            if (len_ok) begin
               len_q <= req_i.dat[na_pkg::LEN_W-1:0];
               cnt_q <= '0;
               state <= S_COLLECT;
               ack_q <= 1'b1;
            end else begin
               err_q <= 1'b1;                     // Bad length, stay idle
            end
         end else if (fifo_valid && fifo_ready) begin
            ack_q <= 1'b1;                        // Withheld while FIFO full
            if (cnt_q == len_q - 1'b1) begin
               cnt_q <= '0;
               state <= S_IDLE;
            end else begin
               cnt_q <= cnt_q + 1'b1;
            end
         end
      end
   end

   // cnt_q stays 0 when idle, so only the open packet's words are held back
   assign release_ok  = (fifo_count > cnt_q);
   assign noc_valid_o = fifo_out_valid & release_ok;
   assign ack_o       = ack_q;
   assign err_o       = err_q;

   na_flit_fifo u_fifo (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .wr_flit_i  (fifo_in),
      .wr_valid_i (fifo_valid),
      .wr_ready_o (fifo_ready),
      .rd_flit_o  (noc_flit_o),
      .rd_valid_o (fifo_out_valid),
      .rd_ready_i (noc_ready_i & release_ok),
      .count_o    (fifo_count)
   );

endmodule

`default_nettype wire

//--- logic/na_bus_decode.sv
/* Bus slave decoder
 * Region select with gated strobes, response mux, err for unmapped regions
 */
`timescale 1ns/1ps
`default_nettype none

module na_bus_decode (
   input  wire logic              clk_i,
   input  wire logic              rst_n_i,
   input  wire na_pkg::wb_req_t   wbs_req_i,
   output na_pkg::wb_rsp_t        wbs_rsp_o,
   output na_pkg::wb_req_t        conf_req_o,
   input  wire na_pkg::wb_rsp_t   conf_rsp_i,
   output na_pkg::wb_req_t        mp_req_o,
   input  wire na_pkg::wb_rsp_t   mp_rsp_i
);

   logic [na_pkg::REGION_W-1:0] region;
   logic                        sel_conf;
   logic                        sel_mp;
   logic                        unmapped;
   logic                        err_q;

   assign region   = wbs_req_i.adr[na_pkg::REGION_LSB+na_pkg::REGION_W-1:na_pkg::REGION_LSB];
   assign sel_conf = (region == na_pkg::REGION_CONF);
   assign sel_mp   = (region == na_pkg::REGION_MP);
   assign unmapped = ~sel_conf & ~sel_mp;      // Regions 2 and 3

   always_comb begin
      conf_req_o     = wbs_req_i;
      conf_req_o.stb = wbs_req_i.stb & sel_conf;
      mp_req_o       = wbs_req_i;
      mp_req_o.stb   = wbs_req_i.stb & sel_mp;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i)
         err_q <= 1'b0;
      else
         err_q <= wbs_req_i.cyc & wbs_req_i.stb & unmapped & ~err_q;
   end

   always_comb begin
      if (sel_conf)
         wbs_rsp_o = conf_rsp_i;
      else if (sel_mp)
         wbs_rsp_o = mp_rsp_i;
      else begin
         wbs_rsp_o.dat = '0;
         wbs_rsp_o.ack = 1'b0;
         wbs_rsp_o.err = err_q;                   // Decoder answers itself
      end
   end

endmodule

`default_nettype wire

//--- logic/na_conf_regs.sv
/* Configuration block
 * Read-only identity and geometry words, writes answered with err
 */
`timescale 1ns/1ps
`default_nettype none

module na_conf_regs #(
   parameter int TILE_ID = 0
) (
   input  wire logic              clk_i,
   input  wire logic              rst_n_i,
   input  wire na_pkg::wb_req_t   req_i,
   output na_pkg::wb_rsp_t        rsp_o
);

   logic [na_pkg::OFFS_W-1:0]   offs;
   logic                        req_seen;
   logic [na_pkg::WB_DAT_W-1:0] rdata;
   logic [na_pkg::WB_DAT_W-1:0] dat_q;
   logic                        ack_q;
   logic                        err_q;

   assign offs     = req_i.adr[na_pkg::REGION_LSB-1:2];
   assign req_seen = req_i.cyc & req_i.stb & ~ack_q & ~err_q;  // Once per access

   always_comb begin
      rdata = '0;                                 // Unknown offsets read 0
      case (offs)
         na_pkg::CONF_TILEID:   rdata = 32'(TILE_ID);
         na_pkg::CONF_XDIM:     rdata = 32'(na_pkg::NOC_XDIM);
         na_pkg::CONF_YDIM:     rdata = 32'(na_pkg::NOC_YDIM);
         na_pkg::CONF_NUMCORES: rdata = 32'(na_pkg::NUM_CORES);
         na_pkg::CONF_COREBASE: rdata = 32'(na_pkg::CORE_BASE);
         na_pkg::CONF_FEATURES: begin
            rdata[na_pkg::FEAT_MP]  = 1'b1;      // Message passing
            rdata[na_pkg::FEAT_DMA] = 1'b0;      // No DMA engine
         end
         default: rdata = '0;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (req_seen)
         dat_q <= rdata;                          // Captured with ack
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= req_seen & ~req_i.we;          // One-cycle pulses
         err_q <= req_seen & req_i.we;
      end
   end

   assign rsp_o.dat = dat_q;
   assign rsp_o.ack = ack_q;
   assign rsp_o.err = err_q;

endmodule

`default_nettype wire

//--- logic/na_flit_fifo.sv
/* Flit FIFO
 * Circular buffer with valid/ready on both sides and fall-through reads
 */
`timescale 1ns/1ps
`default_nettype none

module na_flit_fifo (
   input  wire logic                             clk_i,
   input  wire logic                             rst_n_i,
   input  wire na_pkg::flit_t                    wr_flit_i,
   input  wire logic                             wr_valid_i,
   output logic                                  wr_ready_o,
   output na_pkg::flit_t                         rd_flit_o,
   output logic                                  rd_valid_o,
   input  wire logic                             rd_ready_i,
   output logic [na_pkg::FIFO_CNT_W-1:0]         count_o
);

   na_pkg::flit_t                   mem [na_pkg::MP_FIFO_DEPTH];
   logic [na_pkg::FIFO_PTR_W-1:0]   wr_ptr;    // Wraps at depth
   logic [na_pkg::FIFO_PTR_W-1:0]   rd_ptr;
   logic [na_pkg::FIFO_CNT_W-1:0]   count;
   logic                            push;
   logic                            pop;

   assign wr_ready_o = (count != na_pkg::FIFO_CNT_FULL);
   assign rd_valid_o = (count != '0);
   assign rd_flit_o  = mem[rd_ptr];             // Head visible without a read
   assign count_o    = count;
   assign push       = wr_valid_i & wr_ready_o;
   assign pop        = rd_valid_o & rd_ready_i;

   always_ff @(posedge clk_i) begin
      if (push)
         mem[wr_ptr] <= wr_flit_i;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;           // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

//--- logic/na_pkg.sv
/* Network adapter package
 * Flit and Wishbone types, FIFO sizes and the adapter's address map
 */
`default_nettype none

package na_pkg;

   localparam int FLIT_DATA_W = 32;            // Flit payload
   localparam int FLIT_TYPE_W = 2;             // Flit type field

   typedef enum logic [FLIT_TYPE_W-1:0] {
      FLIT_PAYLOAD = 2'd0,                     // Middle of packet
      FLIT_HEADER  = 2'd1,                     // First of N>1
      FLIT_LAST    = 2'd2,                     // Last of N>1
      FLIT_SINGLE  = 2'd3                      // Whole packet in one flit
   } flit_type_t;

   typedef struct packed {
      flit_type_t             ftype;
      logic [FLIT_DATA_W-1:0] data;
   } flit_t;

   localparam int WB_ADR_W = 32;
   localparam int WB_DAT_W = 32;
   localparam int WB_SEL_W = 4;

   typedef struct packed {
      logic [WB_ADR_W-1:0] adr;
      logic [WB_DAT_W-1:0] dat;
      logic [WB_SEL_W-1:0] sel;
      logic                we;
      logic                cyc;
      logic                stb;
   } wb_req_t;

   typedef struct packed {
      logic [WB_DAT_W-1:0] dat;
      logic                ack;
      logic                err;
   } wb_rsp_t;

   // Address map, region field above a word offset
   localparam int REGION_LSB = 20;
   localparam int REGION_W   = 2;
   localparam int OFFS_W     = REGION_LSB - 2;  // Word offset inside a region
   localparam logic [REGION_W-1:0] REGION_CONF = 2'd0;
   localparam logic [REGION_W-1:0] REGION_MP   = 2'd1;

   localparam int MP_FIFO_DEPTH      = 16;      // Also max packet length
   localparam int FIFO_PTR_W         = $clog2(MP_FIFO_DEPTH);
   localparam int FIFO_CNT_W         = FIFO_PTR_W + 1;
   localparam int LEN_W              = FIFO_CNT_W;
   localparam logic [FIFO_CNT_W-1:0] FIFO_CNT_FULL = FIFO_CNT_W'(MP_FIFO_DEPTH);
   localparam int MP_LEN_QUEUE_DEPTH = 4;
   localparam int LQ_PTR_W           = $clog2(MP_LEN_QUEUE_DEPTH);
   localparam int LQ_CNT_W           = LQ_PTR_W + 1;
   localparam logic [LQ_CNT_W-1:0] LQ_CNT_FULL = LQ_CNT_W'(MP_LEN_QUEUE_DEPTH);

   // System geometry as reported by configuration
   localparam int NOC_XDIM  = 2;
   localparam int NOC_YDIM  = 2;
   localparam int NUM_CORES = 4;
   localparam int CORE_BASE = 0;

   localparam logic [OFFS_W-1:0] CONF_TILEID   = OFFS_W'(0);
   localparam logic [OFFS_W-1:0] CONF_XDIM     = OFFS_W'(1);
   localparam logic [OFFS_W-1:0] CONF_YDIM     = OFFS_W'(2);
   localparam logic [OFFS_W-1:0] CONF_NUMCORES = OFFS_W'(3);
   localparam logic [OFFS_W-1:0] CONF_COREBASE = OFFS_W'(4);
   localparam logic [OFFS_W-1:0] CONF_FEATURES = OFFS_W'(5);

   localparam int FEAT_MP  = 0;                // Bit index, present
   localparam int FEAT_DMA = 1;                // Bit index, absent

   localparam logic [OFFS_W-1:0] MP_DATA   = OFFS_W'(0);
   localparam logic [OFFS_W-1:0] MP_STATUS = OFFS_W'(1);

endpackage

`default_nettype wire
